/* video_defines.svh */
/*
 * Widths for the video path. WIDE_W must stay one bit above COLOR_W,
 * and the output extension assumes OUT_W - WIDE_W <= WIDE_W.
 */
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Colour per channel as produced by the game
`define VIDEO_COLOR_W 4

// After the bandwidth filter, one extra bit for the two-tap sum
`define VIDEO_WIDE_W (`VIDEO_COLOR_W + 1)

// Display side colour per channel
`define VIDEO_OUT_W 8

// Clock cycles from sampled game pixel to out_cen
`define VIDEO_PIPE_LAT 3

`endif

/* video_pkg.sv */
/*
 * Types shared by the video stages. sync_t rides along with every pixel
 * so hs, vs and de stay aligned with colour through the pipeline.
 */
package video_pkg;

    // Fraction of brightness removed on odd lines
    typedef enum logic [1:0] {
        SL_OFF = 2'd0,
        SL_25  = 2'd1,
        SL_50  = 2'd2,
        SL_75  = 2'd3
    } sl_mode_t;

    // Per-pixel timing flags
    typedef struct packed {
        logic hs;
        logic vs;
        logic de;
        logic odd_line;
    } sync_t;

endpackage

/* video_if.sv */
/*
 * Pixel stream between stages. No back-pressure: a pixel exists only
 * in a cycle with valid high and the receiver must take it then.
 */
`include "video_defines.svh"

interface video_if #(
    parameter int COLOR_W = `VIDEO_COLOR_W
);

    // Pixel enable
    logic               valid;
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
    video_pkg::sync_t   sync;

    modport src (
        output valid,
        output r,
        output g,
        output b,
        output sync
    );

    modport dst (
        input valid,
        input r,
        input g,
        input b,
        input sync
    );

endinterface

/* video_capture.sv */
/*
 * First stage. Samples the game outputs when pxl_cen is high.
 * Line parity follows hs rising edges on sampled pixels only and is
 * reset by a vs rising edge, so hs must be seen on at least one pixel.
 */
`include "video_defines.svh"

module video_capture (
    input  logic                      clk_sys,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    input  logic [`VIDEO_COLOR_W-1:0] game_r,
    input  logic [`VIDEO_COLOR_W-1:0] game_g,
    input  logic [`VIDEO_COLOR_W-1:0] game_b,
    input  logic                      lhbl,
    input  logic                      lvbl,
    input  logic                      hs,
    input  logic                      vs,
    video_if.src                      vid
);

    logic             de;
    logic             hs_q;
    logic             vs_q;
    logic             line_odd;
    video_pkg::sync_t sync_nxt;

    // Both blanking signals are active low
    assign de = lhbl & lvbl;

    always_comb begin
        sync_nxt.hs       = hs;
        sync_nxt.vs       = vs;
        sync_nxt.de       = de;
        sync_nxt.odd_line = line_odd;
        // vs wins if both rise on the same pixel
        if (vs && !vs_q) begin
            sync_nxt.odd_line = 1'b0;
        end else if (hs && !hs_q) begin
            sync_nxt.odd_line = ~line_odd;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            vid.valid <= 1'b0;
            vid.sync  <= '0;
            hs_q      <= 1'b0;
            vs_q      <= 1'b0;
            line_odd  <= 1'b0;
        end else begin
            vid.valid <= pxl_cen;
            if (pxl_cen) begin
                vid.sync <= sync_nxt;
                hs_q     <= hs;
                vs_q     <= vs;
                line_odd <= sync_nxt.odd_line;
            end
        end
    end

    // Colour is black outside the active area
    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            vid.r <= de ? game_r : '0;
            vid.g <= de ? game_g : '0;
            vid.b <= de ? game_b : '0;
        end
    end

endmodule

/* video_bw_filter.sv */
/*
 * Second stage. Models the limited bandwidth of an analogue monitor
 * with a two-tap horizontal sum. Output is twice the average, one bit
 * wider than the input. The tap memory restarts at every blanking gap.
 */
`include "video_defines.svh"

module video_bw_filter (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic bw_en,
    video_if.dst vin,
    video_if.src vout
);

    logic [`VIDEO_COLOR_W-1:0] prev_r;
    logic [`VIDEO_COLOR_W-1:0] prev_g;
    logic [`VIDEO_COLOR_W-1:0] prev_b;

    // Sum of current and previous sample, or the current one doubled
    function automatic logic [`VIDEO_WIDE_W-1:0] blend(
        input logic                      en,
        input logic [`VIDEO_COLOR_W-1:0] cur,
        input logic [`VIDEO_COLOR_W-1:0] prv
    );
        logic [`VIDEO_WIDE_W-1:0] other;
        other = en ? {1'b0, prv} : {1'b0, cur};
        return {1'b0, cur} + other;
    endfunction

    // Previous pixel memory
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            prev_r <= '0;
            prev_g <= '0;
            prev_b <= '0;
        end else if (vin.valid) begin
            if (vin.sync.de) begin
                prev_r <= vin.r;
                prev_g <= vin.g;
                prev_b <= vin.b;
            end else begin
                prev_r <= '0;
                prev_g <= '0;
                prev_b <= '0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            vout.valid <= 1'b0;
            vout.sync  <= '0;
        end else begin
            vout.valid <= vin.valid;
            if (vin.valid) begin
                vout.sync <= vin.sync;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (vin.valid) begin
            vout.r <= blend(bw_en, vin.r, prev_r);
            vout.g <= blend(bw_en, vin.g, prev_g);
            vout.b <= blend(bw_en, vin.b, prev_b);
        end
    end

endmodule

/* video_scanline_out.sv */
/*
 * Output stage. Widens colour to 8 bits by repeating the top bits and
 * dims odd lines for a scanline look. Outputs hold between pixels;
 * out_cen marks the cycle in which a new pixel is presented.
 */
`include "video_defines.svh"

module video_scanline_out (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  video_pkg::sl_mode_t     sl_mode,
    video_if.dst                    vin,
    output logic [`VIDEO_OUT_W-1:0] out_r,
    output logic [`VIDEO_OUT_W-1:0] out_g,
    output logic [`VIDEO_OUT_W-1:0] out_b,
    output logic                    out_hs,
    output logic                    out_vs,
    output logic                    out_de,
    output logic                    out_cen
);

    localparam int EXT_W = `VIDEO_OUT_W - `VIDEO_WIDE_W;

    // Append the top bits so full scale maps to full scale
    function automatic logic [`VIDEO_OUT_W-1:0] extend(
        input logic [`VIDEO_WIDE_W-1:0] c
    );
        return {c, c[`VIDEO_WIDE_W-1 -: EXT_W]};
    endfunction

    // Shifts truncate, so dark values may round down to zero
    function automatic logic [`VIDEO_OUT_W-1:0] dim(
        input logic [`VIDEO_OUT_W-1:0] c,
        input video_pkg::sl_mode_t     mode,
        input logic                    odd
    );
        logic [`VIDEO_OUT_W-1:0] res;
        res = c;
        if (odd) begin
            case (mode)
                video_pkg::SL_25: res = c - (c >> 2);
                video_pkg::SL_50: res = c >> 1;
                video_pkg::SL_75: res = c >> 2;
                default:          res = c;
            endcase
        end
        return res;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            out_cen <= 1'b0;
            out_hs  <= 1'b0;
            out_vs  <= 1'b0;
            out_de  <= 1'b0;
            out_r   <= '0;
            out_g   <= '0;
            out_b   <= '0;
        end else begin
            out_cen <= vin.valid;
            if (vin.valid) begin
                out_hs <= vin.sync.hs;
                out_vs <= vin.sync.vs;
                out_de <= vin.sync.de;
                out_r  <= dim(extend(vin.r), sl_mode, vin.sync.odd_line);
                out_g  <= dim(extend(vin.g), sl_mode, vin.sync.odd_line);
                out_b  <= dim(extend(vin.b), sl_mode, vin.sync.odd_line);
            end
        end
    end

endmodule

/* video_board_top.sv */
/*
 * Video output path of the board: capture, bandwidth filter and
 * scanline output. Three cycles of latency from a sampled game pixel
 * to out_cen. bw_en and sl_mode take effect on the next pixel.
 */
`include "video_defines.svh"

module video_board_top (
    input  logic                      clk_sys,
    input  logic                      rst_n,
    input  logic [`VIDEO_COLOR_W-1:0] game_r,
    input  logic [`VIDEO_COLOR_W-1:0] game_g,
    input  logic [`VIDEO_COLOR_W-1:0] game_b,
    input  logic                      lhbl,
    input  logic                      lvbl,
    input  logic                      hs,
    input  logic                      vs,
    input  logic                      pxl_cen,
    input  logic                      bw_en,
    input  video_pkg::sl_mode_t       sl_mode,
    output logic [`VIDEO_OUT_W-1:0]   out_r,
    output logic [`VIDEO_OUT_W-1:0]   out_g,
    output logic [`VIDEO_OUT_W-1:0]   out_b,
    output logic                      out_hs,
    output logic                      out_vs,
    output logic                      out_de,
    output logic                      out_cen
);

    video_if #(.COLOR_W(`VIDEO_COLOR_W)) cap_vid ();
    video_if #(.COLOR_W(`VIDEO_WIDE_W))  flt_vid ();

    video_capture u_capture (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   ),
        .pxl_cen ( pxl_cen ),
        .game_r  ( game_r  ),
        .game_g  ( game_g  ),
        .game_b  ( game_b  ),
        .lhbl    ( lhbl    ),
        .lvbl    ( lvbl    ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .vid     ( cap_vid )
    );

    video_bw_filter u_bw_filter (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   ),
        .bw_en   ( bw_en   ),
        .vin     ( cap_vid ),
        .vout    ( flt_vid )
    );

    video_scanline_out u_scanline_out (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   ),
        .sl_mode ( sl_mode ),
        .vin     ( flt_vid ),
        .out_r   ( out_r   ),
        .out_g   ( out_g   ),
        .out_b   ( out_b   ),
        .out_hs  ( out_hs  ),
        .out_vs  ( out_vs  ),
        .out_de  ( out_de  ),
        .out_cen ( out_cen )
    );

endmodule

/* tb_video_board.sv */
/*
 * Directed testbench for the video output path. A model of the stage
 * rules predicts every output pixel. Outputs are sampled on the falling
 * edge and matched in order, together with the cycle they arrive in.
 */
`include "video_defines.svh"

module tb_video_board;

    localparam int TIMEOUT_CYC = 50;

    logic                      clk_sys = 1'b0;
    logic                      rst_n;
    logic [`VIDEO_COLOR_W-1:0] game_r;
    logic [`VIDEO_COLOR_W-1:0] game_g;
    logic [`VIDEO_COLOR_W-1:0] game_b;
    logic                      lhbl;
    logic                      lvbl;
    logic                      hs;
    logic                      vs;
    logic                      pxl_cen;
    logic                      bw_en;
    video_pkg::sl_mode_t       sl_mode;
    logic [`VIDEO_OUT_W-1:0]   out_r;
    logic [`VIDEO_OUT_W-1:0]   out_g;
    logic [`VIDEO_OUT_W-1:0]   out_b;
    logic                      out_hs;
    logic                      out_vs;
    logic                      out_de;
    logic                      out_cen;

    // Model state for prior pixel memory, line parity and modes
    logic [`VIDEO_COLOR_W-1:0] prev_r;
    logic [`VIDEO_COLOR_W-1:0] prev_g;
    logic [`VIDEO_COLOR_W-1:0] prev_b;
    logic                      last_hs;
    logic                      last_vs;
    logic                      line_odd;
    logic                      use_blend;
    int                        dim_mode;

    int          seed = 60;
    int          cyc = 0;
    int          test_errs;
    int          pass_count;
    int          fail_count;
    // Packed as r, g, b, hs, vs, de
    logic [26:0] exp_q[$];
    int          exp_cyc_q[$];
    logic [26:0] got_q[$];
    int          got_cyc_q[$];

    video_board_top DUT (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   ),
        .game_r  ( game_r  ),
        .game_g  ( game_g  ),
        .game_b  ( game_b  ),
        .lhbl    ( lhbl    ),
        .lvbl    ( lvbl    ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .pxl_cen ( pxl_cen ),
        .bw_en   ( bw_en   ),
        .sl_mode ( sl_mode ),
        .out_r   ( out_r   ),
        .out_g   ( out_g   ),
        .out_b   ( out_b   ),
        .out_hs  ( out_hs  ),
        .out_vs  ( out_vs  ),
        .out_de  ( out_de  ),
        .out_cen ( out_cen )
    );

    always #2 clk_sys = ~clk_sys;

    // cyc numbers the next rising edge
    always @(negedge clk_sys) begin
        cyc = cyc + 1;
        if (out_cen) begin
            got_q.push_back({out_r, out_g, out_b, out_hs, out_vs, out_de});
            got_cyc_q.push_back(cyc);
        end
    end

    // Expected 8-bit channel from the current and previous 4-bit samples
    function automatic logic [7:0] expect_channel(input logic [3:0] cur, input logic [3:0] prv);
        int s;
        int e;
        s = use_blend ? cur + prv : 2 * cur;
        e = s * 8 + s / 4;
        if (line_odd) begin
            case (dim_mode)
                1: e = e - e / 4;
                2: e = e / 2;
                3: e = e / 4;
                default: ;
            endcase
        end
        return e[7:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        if (expv !== actv) begin
            $display("** Error at time %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expv, actv);
            test_errs++;
        end
    endtask

    task automatic check_outputs_zero();
        check_value("out_cen", 32'd0, out_cen);
        check_value("out_de", 32'd0, out_de);
        check_value("out_hs", 32'd0, out_hs);
        check_value("out_vs", 32'd0, out_vs);
        check_value("out_r", 32'd0, out_r);
        check_value("out_g", 32'd0, out_g);
        check_value("out_b", 32'd0, out_b);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            pxl_cen <= 1'b0;
        end
    endtask

    // Only called with the pipeline empty
    task automatic set_modes(input logic bw, input int sl);
        @(posedge clk_sys);
        pxl_cen <= 1'b0;
        bw_en   <= bw;
        sl_mode <= video_pkg::sl_mode_t'(sl);
        use_blend = bw;
        dim_mode  = sl;
    endtask

    task automatic send_pixel(input logic [3:0] r, input logic [3:0] g, input logic [3:0] b,
                              input logic hb, input logic vb, input logic h, input logic v);
        logic       de;
        logic [3:0] cr;
        logic [3:0] cg;
        logic [3:0] cb;
        @(posedge clk_sys);
        game_r  <= r;
        game_g  <= g;
        game_b  <= b;
        lhbl    <= hb;
        lvbl    <= vb;
        hs      <= h;
        vs      <= v;
        pxl_cen <= 1'b1;
        de = hb & vb;
        cr = de ? r : 4'd0;
        cg = de ? g : 4'd0;
        cb = de ? b : 4'd0;
        if (v && !last_vs) begin
            line_odd = 1'b0;
        end else if (h && !last_hs) begin
            line_odd = ~line_odd;
        end
        last_hs = h;
        last_vs = v;
        exp_q.push_back({expect_channel(cr, prev_r), expect_channel(cg, prev_g),
                         expect_channel(cb, prev_b), h, v, de});
        exp_cyc_q.push_back(cyc + 1 + `VIDEO_PIPE_LAT);
        prev_r = cr;
        prev_g = cg;
        prev_b = cb;
    endtask

    task automatic send_active(input int n);
        int rnd;
        repeat (n) begin
            rnd = $random(seed);
            send_pixel(rnd[3:0], rnd[7:4], rnd[11:8], 1'b1, 1'b1, 1'b0, 1'b0);
        end
    endtask

    // Random colour, so forcing to black is visible
    task automatic send_blank(input logic hb, input logic vb, input logic h, input logic v);
        int rnd;
        rnd = $random(seed);
        send_pixel(rnd[3:0], rnd[7:4], rnd[11:8], hb, vb, h, v);
    endtask

    task automatic drain_and_compare(input string name);
        int          waited;
        logic [26:0] e;
        logic [26:0] a;
        idle_cycles(1);
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < TIMEOUT_CYC) begin
            @(posedge clk_sys);
            waited++;
        end
        if (got_q.size() < exp_q.size()) begin
            $display("Timeout in %s: only %0d of %0d pixels came out on out_cen",
                     name, got_q.size(), exp_q.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            idle_cycles(3);
            if (got_q.size() != exp_q.size()) begin
                $display("%s: %0d pixels expected on out_cen but %0d arrived",
                         name, exp_q.size(), got_q.size());
                test_errs++;
            end
            for (int i = 0; i < exp_q.size(); i++) begin
                e = exp_q[i];
                a = got_q[i];
                check_value("out_r", e[26:19], a[26:19]);
                check_value("out_g", e[18:11], a[18:11]);
                check_value("out_b", e[10:3], a[10:3]);
                check_value("out_hs", e[2], a[2]);
                check_value("out_vs", e[1], a[1]);
                check_value("out_de", e[0], a[0]);
                check_value("out_cen cycle", exp_cyc_q[i], got_cyc_q[i]);
            end
            exp_q.delete();
            exp_cyc_q.delete();
            got_q.delete();
            got_cyc_q.delete();
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("Test %s finished without errors", name);
        end else begin
            fail_count++;
            $display("Test %s finished with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        rst_n    = 1'b0;
        game_r   = '0;
        game_g   = '0;
        game_b   = '0;
        lhbl     = 1'b0;
        lvbl     = 1'b0;
        hs       = 1'b0;
        vs       = 1'b0;
        pxl_cen  = 1'b0;
        bw_en    = 1'b0;
        sl_mode  = video_pkg::SL_OFF;
        prev_r   = '0;
        prev_g   = '0;
        prev_b   = '0;
        last_hs  = 1'b0;
        last_vs  = 1'b0;
        line_odd = 1'b0;
        use_blend  = 1'b0;
        dim_mode   = 0;
        test_errs  = 0;
        pass_count = 0;
        fail_count = 0;

        // Reset held for four rising edges, checked during and after
        repeat (3) begin
            @(negedge clk_sys);
            check_outputs_zero();
        end
        @(posedge clk_sys);
        rst_n <= 1'b1;
        repeat (3) begin
            @(negedge clk_sys);
            check_outputs_zero();
        end
        finish_test("reset");

        set_modes(1'b0, 0);
        send_active(12);
        drain_and_compare("bypass");
        finish_test("bypass");

        set_modes(1'b1, 0);
        send_active(6);
        send_blank(1'b0, 1'b1, 1'b0, 1'b0);
        send_blank(1'b0, 1'b1, 1'b0, 1'b0);
        send_active(5);
        idle_cycles(2);
        send_active(3);
        drain_and_compare("filter");
        finish_test("filter");

        set_modes(1'b0, 0);
        send_active(2);
        send_blank(1'b0, 1'b1, 1'b0, 1'b0);
        send_blank(1'b0, 1'b1, 1'b1, 1'b0);
        send_blank(1'b0, 1'b1, 1'b1, 1'b0);
        send_blank(1'b0, 1'b1, 1'b0, 1'b0);
        send_active(2);
        send_blank(1'b1, 1'b0, 1'b0, 1'b1);
        send_blank(1'b0, 1'b0, 1'b0, 1'b1);
        send_blank(1'b1, 1'b0, 1'b0, 1'b0);
        send_active(2);
        drain_and_compare("blanking");
        finish_test("blanking");

        // Per mode: vs, odd line, even line, odd line again, then vs clears it
        for (int m = 0; m < 4; m++) begin
            set_modes(1'b0, m);
            send_blank(1'b1, 1'b0, 1'b0, 1'b1);
            send_blank(1'b1, 1'b0, 1'b0, 1'b0);
            send_blank(1'b0, 1'b1, 1'b1, 1'b0);
            send_blank(1'b0, 1'b1, 1'b0, 1'b0);
            send_pixel(4'hf, 4'hf, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0);
            send_active(3);
            send_blank(1'b0, 1'b1, 1'b1, 1'b0);
            send_blank(1'b0, 1'b1, 1'b0, 1'b0);
            send_pixel(4'hf, 4'hf, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0);
            send_active(2);
            send_blank(1'b0, 1'b1, 1'b1, 1'b0);
            send_blank(1'b0, 1'b1, 1'b0, 1'b0);
            send_active(1);
            send_blank(1'b1, 1'b0, 1'b0, 1'b1);
            send_blank(1'b1, 1'b0, 1'b0, 1'b0);
            send_active(2);
            drain_and_compare("scanlines");
        end
        finish_test("scanlines");

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
video_pkg.sv
video_if.sv
video_capture.sv
video_bw_filter.sv
video_scanline_out.sv
video_board_top.sv
tb_video_board.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_video_board
FILELIST = compile.f
OBJDIR   = obj_dir
LOG      = sim.log
SOURCES  = $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The log decides the result, not the simulator's exit code
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
